// File: hdl/rename_pkg.sv
// ==========================================================================
// Shared sizes and types for the register renaming subsystem
// ==========================================================================
package rename_pkg;

  // Physical register file size, must stay a power of two
  // so that FIFO pointers wrap for free
  localparam int PHY_REG_NUM  = 64;
  // Architectural registers visible to software
  localparam int ARCH_REG_NUM = 32;

  // Slots handled per cycle
  localparam int DECODE_WIDTH = 2;
  localparam int COMMIT_WIDTH = 2;

  // Derived widths
  localparam int PREG_W = $clog2(PHY_REG_NUM);
  localparam int AREG_W = $clog2(ARCH_REG_NUM);
  localparam int CNT_W  = $clog2(PHY_REG_NUM + 1);

  // Physical register number, also a free-list pointer
  typedef logic [PREG_W-1:0] preg_t;
  // Architectural register number
  typedef logic [AREG_W-1:0] areg_t;
  // Free-entry count, 0 up to PHY_REG_NUM inclusive
  typedef logic [CNT_W-1:0]  cnt_t;

  // Whole map table, one physical name per architectural register
  typedef preg_t [ARCH_REG_NUM-1:0] map_t;

  // Slot names within a rename or commit group
  // Slot 0 is the oldest instruction of the group
  typedef enum int unsigned {
    SLOT_0 = 0,
    SLOT_1 = 1
  } slot_e;

endpackage

// File: hdl/free_list_if.sv
`timescale 1ns/1ps

// ==========================================================================
// Free-list port bundle
// ==========================================================================
interface free_list_if import rename_pkg::*; ();

  // Allocation side, driven by the rename stage
  logic [DECODE_WIDTH-1:0] alloc_valid;
  logic                    alloc_ready;
  preg_t [DECODE_WIDTH-1:0] alloc_preg;

  // Release side, driven by the commit stage
  logic [COMMIT_WIDTH-1:0]  free_valid;
  preg_t [COMMIT_WIDTH-1:0] free_preg;

  // Committed FIFO state, used to restore on flush
  preg_t arch_head;
  preg_t arch_tail;
  cnt_t  arch_cnt;

  // Rename stage view
  modport alloc (output alloc_valid, input alloc_ready, input alloc_preg);

  // Commit stage view
  modport rel (output free_valid, output free_preg,
               output arch_head, output arch_tail, output arch_cnt);

  // The FIFO itself
  modport list (input alloc_valid, output alloc_ready, output alloc_preg,
                input free_valid, input free_preg,
                input arch_head, input arch_tail, input arch_cnt);

endinterface

// File: hdl/free_list.sv
`timescale 1ns/1ps

// ==========================================================================
// Circular FIFO of free physical register numbers
// ==========================================================================
module free_list import rename_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       flush_i,
  free_list_if.list fl
);

  // Storage and pointers
  preg_t [PHY_REG_NUM-1:0] list_q;
  preg_t [PHY_REG_NUM-1:0] list_n;
  preg_t                   head_q;
  preg_t                   head_n;
  preg_t                   tail_q;
  preg_t                   tail_n;
  cnt_t                    cnt_q;
  cnt_t                    cnt_n;

  // Per-slot read and write positions
  preg_t [DECODE_WIDTH-1:0] rd_idx;
  preg_t [COMMIT_WIDTH-1:0] wr_idx;

  // Request sizes this cycle
  cnt_t alloc_num;
  cnt_t alloc_take;
  cnt_t free_num;

  // Enough entries for a full group, whatever its size
  assign fl.alloc_ready = (cnt_q >= cnt_t'(DECODE_WIDTH));

  // ==========================================================================
  // Next-state logic
  // ==========================================================================
  always_comb begin
    alloc_num  = cnt_t'($countones(fl.alloc_valid));
    free_num   = cnt_t'($countones(fl.free_valid));
    // Nothing leaves the list unless ready
    alloc_take = fl.alloc_ready ? alloc_num : '0;

    // Valid bits are packed from slot 0, so slot i reads head + i
    // Pointer width matches the array, wrap is implicit
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      rd_idx[i] = head_q + preg_t'(i);
      if (fl.alloc_valid[i]) begin
        fl.alloc_preg[i] = list_q[rd_idx[i]];
      end else begin
        fl.alloc_preg[i] = '0;
      end
    end

    // Returned names land at the tail in slot order
    list_n = list_q;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      wr_idx[i] = tail_q + preg_t'(i);
      if (fl.free_valid[i]) begin
        list_n[wr_idx[i]] = fl.free_preg[i];
      end
    end

    head_n = head_q + preg_t'(alloc_take);
    tail_n = tail_q + preg_t'(free_num);
    cnt_n  = cnt_q + free_num - alloc_take;

    // Flush rewinds to the committed view
    // Arch values already include this cycle's retirements
    if (flush_i) begin
      head_n = fl.arch_head;
      tail_n = fl.arch_tail;
      cnt_n  = fl.arch_cnt;
    end
  end

  // ==========================================================================
  // State
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Low entries start as 32..63, the rest gets overwritten by frees
      for (int i = 0; i < PHY_REG_NUM; i++) begin
        list_q[i] <= preg_t'(i + ARCH_REG_NUM);
      end
      head_q <= '0;
      tail_q <= preg_t'(ARCH_REG_NUM);
      cnt_q  <= cnt_t'(PHY_REG_NUM - ARCH_REG_NUM);
    end else begin
      // Frees are never blocked
      list_q <= list_n;
      head_q <= head_n;
      tail_q <= tail_n;
      cnt_q  <= cnt_n;
    end
  end

  // ==========================================================================
  // Checks
  // ==========================================================================
  // Count never runs past capacity, even across flushes
  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= cnt_t'(PHY_REG_NUM));

  // Alloc requests packed from slot 0
  a_alloc_contig: assert property (@(posedge clk) disable iff (!rst_n)
    (fl.alloc_valid & (fl.alloc_valid + DECODE_WIDTH'(1))) == '0);

  // Frees packed from slot 0
  a_free_contig: assert property (@(posedge clk) disable iff (!rst_n)
    (fl.free_valid & (fl.free_valid + COMMIT_WIDTH'(1))) == '0);

endmodule

// File: hdl/rename_map.sv
`timescale 1ns/1ps

// ==========================================================================
// Speculative rename table
// ==========================================================================
module rename_map import rename_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,

  // Rename group from decode
  input  logic [DECODE_WIDTH-1:0]  rn_valid_i,
  input  areg_t [DECODE_WIDTH-1:0] rn_areg_i,
  output logic                     rn_ready_o,
  output preg_t [DECODE_WIDTH-1:0] rn_preg_o,
  output preg_t [DECODE_WIDTH-1:0] rn_old_preg_o,

  // Committed table for flush restore
  input  map_t                     arch_map_i,

  free_list_if.alloc               fl
);

  map_t map_q;
  map_t map_n;
  logic accept;

  // Straight request to the FIFO, level style
  assign fl.alloc_valid = rn_valid_i;
  assign rn_ready_o     = fl.alloc_ready;
  // New names come directly from the FIFO head
  assign rn_preg_o      = fl.alloc_preg;

  // Group taken this cycle
  assign accept = (rn_valid_i != '0) && fl.alloc_ready;

  // ==========================================================================
  // Old mapping lookup
  // ==========================================================================
  always_comb begin
    for (int s = int'(SLOT_0); s < DECODE_WIDTH; s++) begin
      rn_old_preg_o[s] = map_q[rn_areg_i[s]];
      // Older slot in the same group writing the same areg
      // Later older slot wins, so scan upward
      for (int p = int'(SLOT_0); p < s; p++) begin
        if (rn_valid_i[p] && (rn_areg_i[p] == rn_areg_i[s])) begin
          rn_old_preg_o[s] = fl.alloc_preg[p];
        end
      end
    end
  end

  // ==========================================================================
  // Table update
  // ==========================================================================
  always_comb begin
    map_n = map_q;
    if (flush_i) begin
      // Rename in the flush cycle is dropped
      map_n = arch_map_i;
    end else if (accept) begin
      // Slot order, youngest write sticks
      for (int s = int'(SLOT_0); s < DECODE_WIDTH; s++) begin
        if (rn_valid_i[s]) begin
          map_n[rn_areg_i[s]] = fl.alloc_preg[s];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity map, areg n lives in preg n
      for (int i = 0; i < ARCH_REG_NUM; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else begin
      map_q <= map_n;
    end
  end

  // ==========================================================================
  // Checks
  // ==========================================================================
  // No group is taken in a flush cycle
  a_flush_no_accept: assert property (@(posedge clk) disable iff (!rst_n)
    flush_i |-> !accept);

  // An accepted group must consume distinct new names
  a_distinct_alloc: assert property (@(posedge clk) disable iff (!rst_n)
    (accept && rn_valid_i[SLOT_1]) |-> (rn_preg_o[SLOT_0] != rn_preg_o[SLOT_1]));

endmodule

// File: hdl/commit_map.sv
`timescale 1ns/1ps

// ==========================================================================
// Architectural rename table and committed free-list pointers
// ==========================================================================
module commit_map import rename_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,

  // Retiring destinations, in program order from slot 0
  input  logic [COMMIT_WIDTH-1:0]  cm_valid_i,
  input  areg_t [COMMIT_WIDTH-1:0] cm_areg_i,
  input  preg_t [COMMIT_WIDTH-1:0] cm_preg_i,

  // Committed table for the speculative side
  output map_t                     arch_map_o,

  free_list_if.rel                 fl
);

  map_t  map_q;
  map_t  map_n;
  preg_t head_q;
  preg_t head_n;
  preg_t tail_q;
  preg_t tail_n;

  // Retire and release sizes
  cnt_t  cm_num;
  cnt_t  free_num;

  // One release per retiring destination
  assign fl.free_valid = cm_valid_i;

  // ==========================================================================
  // Map update and displaced names
  // ==========================================================================
  always_comb begin
    map_n = map_q;
    // Reading the running copy gives intra-group forwarding
    // Slot 1 on the same areg frees slot 0's preg
    for (int s = int'(SLOT_0); s < COMMIT_WIDTH; s++) begin
      fl.free_preg[s] = '0;
      if (cm_valid_i[s]) begin
        fl.free_preg[s]       = map_n[cm_areg_i[s]];
        map_n[cm_areg_i[s]]   = cm_preg_i[s];
      end
    end
  end

  // ==========================================================================
  // Committed pointers
  // ==========================================================================
  always_comb begin
    cm_num   = cnt_t'($countones(cm_valid_i));
    free_num = cnt_t'($countones(fl.free_valid));
    // Head skips past names now owned by retired instructions
    head_n   = head_q + preg_t'(cm_num);
    // Tail follows the names just returned
    tail_n   = tail_q + preg_t'(free_num);
  end

  // Next-state values go out, so a flush in a commit cycle
  // restores a view that already holds those retirements
  assign arch_map_o   = map_n;
  assign fl.arch_head = head_n;
  assign fl.arch_tail = tail_n;

  // Every retire frees one name so the committed count stays at reset value
  assign fl.arch_cnt  = cnt_t'(PHY_REG_NUM - ARCH_REG_NUM);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ARCH_REG_NUM; i++) begin
        map_q[i] <= preg_t'(i);
      end
      // Same as the FIFO reset
      head_q <= '0;
      tail_q <= preg_t'(ARCH_REG_NUM);
    end else begin
      map_q  <= map_n;
      head_q <= head_n;
      tail_q <= tail_n;
    end
  end

  // ==========================================================================
  // Checks
  // ==========================================================================
  // Retire group packed from slot 0
  a_cm_contig: assert property (@(posedge clk) disable iff (!rst_n)
    (cm_valid_i & (cm_valid_i + COMMIT_WIDTH'(1))) == '0);

endmodule

// File: hdl/rename_core.sv
`timescale 1ns/1ps

// ==========================================================================
// Renaming subsystem top
// ==========================================================================
module rename_core import rename_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,

  // Rename group
  input  logic [DECODE_WIDTH-1:0]  rn_valid_i,
  input  areg_t [DECODE_WIDTH-1:0] rn_areg_i,
  output logic                     rn_ready_o,
  output preg_t [DECODE_WIDTH-1:0] rn_preg_o,
  output preg_t [DECODE_WIDTH-1:0] rn_old_preg_o,

  // Commit group
  input  logic [COMMIT_WIDTH-1:0]  cm_valid_i,
  input  areg_t [COMMIT_WIDTH-1:0] cm_areg_i,
  input  preg_t [COMMIT_WIDTH-1:0] cm_preg_i
);

  // FIFO bundle between the three blocks
  free_list_if fl_if ();

  // Committed table, flush source for the speculative map
  map_t arch_map;

  // Free-name FIFO
  free_list u_free_list (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .fl      (fl_if.list)
  );

  // Producer side
  rename_map u_rename_map (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .rn_valid_i    (rn_valid_i),
    .rn_areg_i     (rn_areg_i),
    .rn_ready_o    (rn_ready_o),
    .rn_preg_o     (rn_preg_o),
    .rn_old_preg_o (rn_old_preg_o),
    .arch_map_i    (arch_map),
    .fl            (fl_if.alloc)
  );

  // Consumer side
  commit_map u_commit_map (
    .clk        (clk),
    .rst_n      (rst_n),
    .cm_valid_i (cm_valid_i),
    .cm_areg_i  (cm_areg_i),
    .cm_preg_i  (cm_preg_i),
    .arch_map_o (arch_map),
    .fl         (fl_if.rel)
  );

endmodule

// File: verif/tb_rename_core.sv
`timescale 1ns/1ps

// ==========================================================================
// Testbench for the renaming subsystem
// ==========================================================================
module tb_rename_core import rename_pkg::*; ();

  // Stall cycles tolerated while waiting for rn_ready_o
  localparam int READY_TIMEOUT = 20;

  logic                     clk;
  logic                     rst_n;
  logic                     flush_i;
  logic [DECODE_WIDTH-1:0]  rn_valid_i;
  areg_t [DECODE_WIDTH-1:0] rn_areg_i;
  logic                     rn_ready_o;
  preg_t [DECODE_WIDTH-1:0] rn_preg_o;
  preg_t [DECODE_WIDTH-1:0] rn_old_preg_o;
  logic [COMMIT_WIDTH-1:0]  cm_valid_i;
  areg_t [COMMIT_WIDTH-1:0] cm_areg_i;
  preg_t [COMMIT_WIDTH-1:0] cm_preg_i;

  // Reference model, free names in allocation order
  preg_t free_q[$];
  // Renamed but not yet retired, oldest first
  areg_t pend_areg[$];
  preg_t pend_preg[$];
  preg_t spec_m [ARCH_REG_NUM];
  preg_t arch_m [ARCH_REG_NUM];

  // Expected responses for the cycle in flight
  logic                     exp_ready;
  logic                     exp_accept;
  preg_t [DECODE_WIDTH-1:0] exp_preg;
  preg_t [DECODE_WIDTH-1:0] exp_old;

  int unsigned seed;
  int          errors;
  int          n_groups;

  rename_core DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .rn_valid_i    (rn_valid_i),
    .rn_areg_i     (rn_areg_i),
    .rn_ready_o    (rn_ready_o),
    .rn_preg_o     (rn_preg_o),
    .rn_old_preg_o (rn_old_preg_o),
    .cm_valid_i    (cm_valid_i),
    .cm_areg_i     (cm_areg_i),
    .cm_preg_i     (cm_preg_i)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // ==========================================================================
  // Checks against the model
  // ==========================================================================
  a_ready: assert property (@(posedge clk) disable iff (!rst_n)
    rn_ready_o == exp_ready)
    else begin
      errors++;
      $display("CHECK FAILED rn_ready_o: got %h expected %h",
               $sampled(rn_ready_o), $sampled(exp_ready));
    end

  for (genvar s = 0; s < DECODE_WIDTH; s++) begin : g_slot_chk
    // New name, FIFO order
    a_preg: assert property (@(posedge clk) disable iff (!rst_n)
      (exp_accept && rn_valid_i[s]) |-> (rn_preg_o[s] == exp_preg[s]))
      else begin
        errors++;
        $display("CHECK FAILED rn_preg_o[%0d]: got %h expected %h", s,
                 $sampled(rn_preg_o[s]), $sampled(exp_preg[s]));
      end
    // Displaced name, with same-group forwarding
    a_old: assert property (@(posedge clk) disable iff (!rst_n)
      (exp_accept && rn_valid_i[s]) |-> (rn_old_preg_o[s] == exp_old[s]))
      else begin
        errors++;
        $display("CHECK FAILED rn_old_preg_o[%0d]: got %h expected %h", s,
                 $sampled(rn_old_preg_o[s]), $sampled(exp_old[s]));
      end
  end

  // ==========================================================================
  // Model and stimulus helpers
  // ==========================================================================
  function automatic int unsigned lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed >> 8;
  endfunction

  // Expected outputs for the inputs now driven
  function automatic void predict();
    exp_ready  = (free_q.size() >= DECODE_WIDTH);
    exp_accept = (rn_valid_i != '0) && exp_ready && !flush_i;
    for (int s = 0; s < DECODE_WIDTH; s++) begin
      exp_preg[s] = (s < free_q.size()) ? free_q[s] : '0;
      exp_old[s]  = spec_m[rn_areg_i[s]];
      // Older slot of the same group on the same areg
      for (int p = 0; p < s; p++) begin
        if (rn_valid_i[p] && (rn_areg_i[p] == rn_areg_i[s])) begin
          exp_old[s] = exp_preg[p];
        end
      end
    end
  endfunction

  // What the last edge did, in program order
  function automatic void update_model();
    preg_t grant;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      if (cm_valid_i[i]) begin
        free_q.push_back(arch_m[cm_areg_i[i]]);
        arch_m[cm_areg_i[i]] = cm_preg_i[i];
        void'(pend_areg.pop_front());
        void'(pend_preg.pop_front());
      end
    end
    if (flush_i) begin
      // Uncommitted names go back in front of the free ones
      spec_m = arch_m;
      for (int i = pend_preg.size() - 1; i >= 0; i--) begin
        free_q.push_front(pend_preg[i]);
      end
      pend_preg.delete();
      pend_areg.delete();
    end else if (exp_accept) begin
      n_groups++;
      for (int s = 0; s < DECODE_WIDTH; s++) begin
        if (rn_valid_i[s]) begin
          grant = free_q.pop_front();
          spec_m[rn_areg_i[s]] = grant;
          pend_areg.push_back(rn_areg_i[s]);
          pend_preg.push_back(grant);
        end
      end
    end
  endfunction

  // Retire the oldest n pending destinations next edge
  function automatic void set_commit(int n);
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      cm_valid_i[i] = (i < n) && (i < pend_preg.size());
      cm_areg_i[i]  = cm_valid_i[i] ? pend_areg[i] : '0;
      cm_preg_i[i]  = cm_valid_i[i] ? pend_preg[i] : '0;
    end
  endfunction

  // One clock, commit and flush are single-cycle strobes
  task automatic tick();
    @(posedge clk);
    #1;
    update_model();
    flush_i    = 1'b0;
    cm_valid_i = '0;
    predict();
  endtask

  task automatic finish_run();
    $display("Checked %0d rename groups, %0d errors", n_groups, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  // Stalled cycles retire one destination each
  task automatic wait_ready();
    int waited;
    waited = 0;
    while (rn_ready_o !== 1'b1 && waited < READY_TIMEOUT) begin
      if (cm_valid_i == '0) begin
        set_commit(1);
      end
      tick();
      waited++;
    end
    if (rn_ready_o !== 1'b1) begin
      $display("Timeout: rn_ready_o stayed low for %0d cycles", READY_TIMEOUT);
      errors++;
    end
  endtask

  task automatic rename_group(logic [DECODE_WIDTH-1:0] v, areg_t a0, areg_t a1);
    rn_valid_i   = v;
    rn_areg_i[0] = a0;
    rn_areg_i[1] = a1;
    predict();
    wait_ready();
    tick();
    rn_valid_i = '0;
    predict();
  endtask

  task automatic random_group();
    logic [DECODE_WIDTH-1:0] v;
    v = (lcg_next() % 2 == 0) ? 2'b11 : 2'b01;
    rename_group(v, areg_t'(lcg_next()), areg_t'(lcg_next()));
  endtask

  task automatic do_flush();
    rn_valid_i = '0;
    flush_i    = 1'b1;
    predict();
    tick();
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    flush_i    = 1'b0;
    rn_valid_i = '0;
    rn_areg_i  = '0;
    cm_valid_i = '0;
    cm_areg_i  = '0;
    cm_preg_i  = '0;
    seed       = 82;
    errors     = 0;
    n_groups   = 0;
    // Identity map, names 32..63 free
    for (int i = 0; i < ARCH_REG_NUM; i++) begin
      spec_m[i] = preg_t'(i);
      arch_m[i] = preg_t'(i);
    end
    for (int i = ARCH_REG_NUM; i < PHY_REG_NUM; i++) begin
      free_q.push_back(preg_t'(i));
    end
    predict();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // FIFO order from reset, old names from the identity table
    for (int g = 0; g < 4; g++) begin
      rename_group(2'b11, areg_t'(lcg_next()), areg_t'(lcg_next()));
    end
    // Both slots on one areg, then reuse it
    rename_group(2'b11, areg_t'(5), areg_t'(5));
    rename_group(2'b11, areg_t'(5), areg_t'(9));

    // Ten more full groups empty the list
    for (int g = 0; g < 10; g++) begin
      rename_group(2'b11, areg_t'(lcg_next()), areg_t'(lcg_next()));
    end
    // Held group under back-pressure
    rn_valid_i   = 2'b11;
    rn_areg_i[0] = areg_t'(3);
    rn_areg_i[1] = areg_t'(17);
    predict();
    repeat (3) tick();
    set_commit(2);
    wait_ready();
    tick();
    rn_valid_i = '0;
    predict();

    // Steady retire and rename, recycled names follow queued ones
    for (int k = 0; k < 40; k++) begin
      set_commit(1 + int'(lcg_next() % 2));
      random_group();
    end

    // Flush with renames pending
    do_flush();
    for (int k = 0; k < 4; k++) begin
      random_group();
    end
    // Retire and flush in one cycle
    set_commit(1);
    do_flush();
    for (int k = 0; k < 4; k++) begin
      random_group();
    end

    // Drain, then a last few groups
    while (pend_preg.size() > 0) begin
      set_commit(2);
      tick();
    end
    for (int k = 0; k < 6; k++) begin
      random_group();
    end
    finish_run();
  end

endmodule

// File: rename_core.f
hdl/rename_pkg.sv
hdl/free_list_if.sv
hdl/free_list.sv
hdl/rename_map.sv
hdl/commit_map.sv
hdl/rename_core.sv
verif/tb_rename_core.sv

// File: Makefile
TOP       ?= tb_rename_core
FILELIST  ?= rename_core.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
OBJ_DIR   ?= obj_dir

TB_SRC  := verif/tb_rename_core.sv
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(TB_SRC) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
